// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_aim_video
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES) testbench/aim_video_testdata.hex
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# Verilator stops at the first $error unless the limit is raised
run: compile
	./$(BUILD)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: capture/cam_capture.sv
`timescale 1ns/10ps

module cam_capture #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_vsync,
    input  logic                   i_href,
    input  logic                   i_byte_en,
    input  logic [7:0]             i_data,
    output video_pkg::pixel_pack_t o_pack
);

    import video_pkg::*;

    logic       href_q;
    logic       phase;                                  // High while a high byte waits
    logic [7:0] hi_byte;
    pix_x_t     x_cnt;
    pix_y_t     y_cnt;

    logic take;
    logic href_rise;
    logic href_fall;
    logic first_byte;
    logic in_frame;
    logic emit;

    assign take       = i_byte_en && i_href;
    assign href_rise  = i_href && !href_q;
    assign href_fall  = !i_href && href_q;
    assign first_byte = href_rise || !phase;            // A new line always opens a new pair
    assign in_frame   = (x_cnt < pix_x_t'(H_ACT)) && (y_cnt < pix_y_t'(V_ACT));
    assign emit       = take && !first_byte && !i_vsync && in_frame;

    // Byte pairing and raster position
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            href_q <= 1'b0;
            phase  <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else begin
            href_q <= i_href;
            if (i_vsync) begin
                phase <= 1'b0;
                x_cnt <= '0;
                y_cnt <= '0;
            end else begin
                if (take) begin
                    phase <= first_byte;
                end else if (href_rise) begin
                    phase <= 1'b0;
                end

                if (href_fall) begin
                    x_cnt <= '0;
                    if (y_cnt < pix_y_t'(V_ACT)) begin
                        y_cnt <= y_cnt + pix_y_t'(1);   // Saturates one past the last row
                    end
                end else if (emit) begin
                    x_cnt <= x_cnt + pix_x_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && first_byte) begin
            hi_byte <= i_data;
        end
    end

    // Flags follow the bytes by one cycle so they stay aligned with the pixel
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pack.vsync <= 1'b0;
            o_pack.href  <= 1'b0;
            o_pack.de    <= 1'b0;
        end else begin
            o_pack.vsync <= i_vsync;
            o_pack.href  <= i_href;
            o_pack.de    <= emit;
        end
        if (emit) begin
            o_pack.x   <= x_cnt;
            o_pack.y   <= y_cnt;
            o_pack.rgb <= {hi_byte, i_data};
        end
    end

endmodule : cam_capture

// File: common/video_pkg.sv
package video_pkg;

    //////////////////////////////
    // Pixel stream
    //////////////////////////////

    typedef logic [10:0] pix_x_t;                // Column inside the active line
    typedef logic [9:0]  pix_y_t;                // Row inside the active frame

    typedef struct packed {
        logic        vsync;                      // Frame marker
        logic        href;                       // Line active
        logic        de;                         // Pixel valid this cycle
        pix_x_t      x;
        pix_y_t      y;
        logic [15:0] rgb;                        // RGB565
    } pixel_pack_t;

    //////////////////////////////
    // Box overlay setup
    //////////////////////////////

    typedef struct packed {
        pix_x_t      start_x;
        pix_y_t      start_y;
        pix_x_t      end_x;
        pix_y_t      end_y;
        logic [15:0] color;                      // RGB565 outline color
        logic        en;
    } box_cfg_t;

    //////////////////////////////
    // APB register map
    //////////////////////////////

    typedef logic [7:0] apb_addr_t;

    localparam apb_addr_t ADDR_CTRL  = 8'h00;    // Camera select and box enable
    localparam apb_addr_t ADDR_BOX_X = 8'h04;    // Start x low half, end x high half
    localparam apb_addr_t ADDR_BOX_Y = 8'h08;    // Start y low half, end y high half
    localparam apb_addr_t ADDR_COLOR = 8'h0C;

    localparam int CTRL_SEL_BIT    = 0;
    localparam int CTRL_BOX_EN_BIT = 1;

endpackage : video_pkg

// File: process/box_overlay.sv
`timescale 1ns/10ps

module box_overlay #(
    parameter int BORDER = 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  video_pkg::pixel_pack_t i_pack,
    input  video_pkg::box_cfg_t    i_box,
    output video_pkg::pixel_pack_t o_pack
);

    logic in_box;
    logic near_edge;
    logic paint;

    //////////////////////////////
    // Outline hit test
    //////////////////////////////

    always_comb begin
        in_box = (i_pack.x >= i_box.start_x) && (i_pack.x <= i_box.end_x)
              && (i_pack.y >= i_box.start_y) && (i_pack.y <= i_box.end_y);

        // Integer math keeps the far edge from wrapping when it is near zero
        near_edge = (int'(i_pack.x) < int'(i_box.start_x) + BORDER)
                 || (int'(i_pack.x) + BORDER > int'(i_box.end_x))
                 || (int'(i_pack.y) < int'(i_box.start_y) + BORDER)
                 || (int'(i_pack.y) + BORDER > int'(i_box.end_y));

        paint = i_box.en && i_pack.de && in_box && near_edge;
    end

    //////////////////////////////
    // Output stage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pack.vsync <= 1'b0;
            o_pack.href  <= 1'b0;
            o_pack.de    <= 1'b0;
        end else begin
            o_pack.vsync <= i_pack.vsync;
            o_pack.href  <= i_pack.href;
            o_pack.de    <= i_pack.de;
        end
        o_pack.x   <= i_pack.x;
        o_pack.y   <= i_pack.y;
        o_pack.rgb <= paint ? i_box.color : i_pack.rgb;    // Outline replaces the camera pixel
    end

endmodule : box_overlay

// File: project.f
common/video_pkg.sv
capture/cam_capture.sv
process/box_overlay.sv
src/apb_regs.sv
src/stream_select.sv
src/video_out.sv
src/aim_video_top.sv
testbench/aim_video_props.sv
testbench/tb_aim_video.sv

// File: src/aim_video_top.sv
`timescale 1ns/10ps

module aim_video_top #(
    parameter int H_ACT  = 1280,
    parameter int V_ACT  = 720,
    parameter int BORDER = 2
) (
    input  logic        clk,
    input  logic        i_rst_n,

    input  logic        i_cam1_vsync,
    input  logic        i_cam1_href,
    input  logic        i_cam1_byte_en,
    input  logic [7:0]  i_cam1_data,

    input  logic        i_cam2_vsync,
    input  logic        i_cam2_href,
    input  logic        i_cam2_byte_en,
    input  logic [7:0]  i_cam2_data,

    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr,

    output logic        o_vsync,
    output logic        o_hsync,
    output logic        o_de,
    output logic [7:0]  o_r,
    output logic [7:0]  o_g,
    output logic [7:0]  o_b
);

    import video_pkg::*;

    pixel_pack_t cam1_pack;
    pixel_pack_t cam2_pack;
    pixel_pack_t cam1_ovl;
    pixel_pack_t cam2_ovl;
    pixel_pack_t out_pack;
    box_cfg_t    box_cfg;
    logic        cam_sel;

    //////////////////////////////
    // Camera input side
    //////////////////////////////

    cam_capture #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_cam1_capture (
        .clk      (clk           ),
        .i_rst_n  (i_rst_n       ),
        .i_vsync  (i_cam1_vsync  ),
        .i_href   (i_cam1_href   ),
        .i_byte_en(i_cam1_byte_en),
        .i_data   (i_cam1_data   ),
        .o_pack   (cam1_pack     )
    );

    cam_capture #(.H_ACT(H_ACT), .V_ACT(V_ACT)) u_cam2_capture (
        .clk      (clk           ),
        .i_rst_n  (i_rst_n       ),
        .i_vsync  (i_cam2_vsync  ),
        .i_href   (i_cam2_href   ),
        .i_byte_en(i_cam2_byte_en),
        .i_data   (i_cam2_data   ),
        .o_pack   (cam2_pack     )
    );

    //////////////////////////////
    // Box overlay per camera
    //////////////////////////////

    box_overlay #(.BORDER(BORDER)) u_cam1_overlay (
        .clk    (clk      ),
        .i_rst_n(i_rst_n  ),
        .i_pack (cam1_pack),
        .i_box  (box_cfg  ),
        .o_pack (cam1_ovl )
    );

    box_overlay #(.BORDER(BORDER)) u_cam2_overlay (
        .clk    (clk      ),
        .i_rst_n(i_rst_n  ),
        .i_pack (cam2_pack),
        .i_box  (box_cfg  ),
        .o_pack (cam2_ovl )
    );

    //////////////////////////////
    // Output side
    //////////////////////////////

    stream_select u_stream_select (
        .clk     (clk     ),
        .i_rst_n (i_rst_n ),
        .i_pack_a(cam1_ovl),
        .i_pack_b(cam2_ovl),
        .i_sel   (cam_sel ),
        .o_pack  (out_pack)
    );

    video_out u_video_out (
        .clk    (clk     ),
        .i_rst_n(i_rst_n ),
        .i_pack (out_pack),
        .o_vsync(o_vsync ),
        .o_hsync(o_hsync ),
        .o_de   (o_de    ),
        .o_r    (o_r     ),
        .o_g    (o_g     ),
        .o_b    (o_b     )
    );

    apb_regs u_apb_regs (
        .clk      (clk      ),
        .i_rst_n  (i_rst_n  ),
        .i_psel   (i_psel   ),
        .i_penable(i_penable),
        .i_pwrite (i_pwrite ),
        .i_paddr  (i_paddr  ),
        .i_pwdata (i_pwdata ),
        .o_prdata (o_prdata ),
        .o_pready (o_pready ),
        .o_pslverr(o_pslverr),
        .o_box    (box_cfg  ),
        .o_cam_sel(cam_sel  )
    );

endmodule : aim_video_top

// File: src/apb_regs.sv
`timescale 1ns/10ps

module apb_regs (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_psel,
    input  logic                i_penable,
    input  logic                i_pwrite,
    input  logic [7:0]          i_paddr,
    input  logic [31:0]         i_pwdata,
    output logic [31:0]         o_prdata,
    output logic                o_pready,
    output logic                o_pslverr,
    output video_pkg::box_cfg_t o_box,
    output logic                o_cam_sel
);

    import video_pkg::*;

    logic        setup;
    logic        wr_en;
    logic        addr_hit;
    logic [31:0] rd_data;

    assign setup = i_psel && !i_penable;
    assign wr_en = i_psel && i_penable && i_pwrite;     // Takes effect on the access edge

    //////////////////////////////
    // Address decode
    //////////////////////////////

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (i_paddr)
            ADDR_CTRL:  rd_data = {30'd0, o_box.en, o_cam_sel};
            ADDR_BOX_X: rd_data = {5'd0, o_box.end_x, 5'd0, o_box.start_x};
            ADDR_BOX_Y: rd_data = {6'd0, o_box.end_y, 6'd0, o_box.start_y};
            ADDR_COLOR: rd_data = {16'd0, o_box.color};
            default:    addr_hit = 1'b0;
        endcase
    end

    // Response is set up in the setup phase and shows during the access phase
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pready  <= 1'b0;
            o_pslverr <= 1'b0;
        end else begin
            o_pready  <= setup;
            o_pslverr <= setup && !addr_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            o_prdata <= i_pwrite ? 32'd0 : rd_data;
        end
    end

    //////////////////////////////
    // Register storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_box     <= '0;
            o_cam_sel <= 1'b0;
        end else if (wr_en) begin
            case (i_paddr)
                ADDR_CTRL: begin
                    o_cam_sel <= i_pwdata[CTRL_SEL_BIT];
                    o_box.en  <= i_pwdata[CTRL_BOX_EN_BIT];
                end
                ADDR_BOX_X: begin
                    o_box.start_x <= i_pwdata[10:0];
                    o_box.end_x   <= i_pwdata[26:16];
                end
                ADDR_BOX_Y: begin
                    o_box.start_y <= i_pwdata[9:0];
                    o_box.end_y   <= i_pwdata[25:16];
                end
                ADDR_COLOR: o_box.color <= i_pwdata[15:0];
                default: begin
                end
            endcase
        end
    end

endmodule : apb_regs

// File: src/stream_select.sv
`timescale 1ns/10ps

module stream_select (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  video_pkg::pixel_pack_t i_pack_a,
    input  video_pkg::pixel_pack_t i_pack_b,
    input  logic                   i_sel,
    output video_pkg::pixel_pack_t o_pack
);

    logic sel_q;                                    // Source of the frame now on the output
    logic new_vsync;
    logic sel_next;

    assign new_vsync = i_sel ? i_pack_b.vsync : i_pack_a.vsync;
    assign sel_next  = ((i_sel != sel_q) && new_vsync) ? i_sel : sel_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sel_q <= 1'b0;
        end else begin
            sel_q <= sel_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_pack.vsync <= 1'b0;
            o_pack.href  <= 1'b0;
            o_pack.de    <= 1'b0;
        end else begin
            o_pack.vsync <= sel_next ? i_pack_b.vsync : i_pack_a.vsync;
            o_pack.href  <= sel_next ? i_pack_b.href : i_pack_a.href;
            o_pack.de    <= sel_next ? i_pack_b.de : i_pack_a.de;
        end
        o_pack.x   <= sel_next ? i_pack_b.x : i_pack_a.x;
        o_pack.y   <= sel_next ? i_pack_b.y : i_pack_a.y;
        o_pack.rgb <= sel_next ? i_pack_b.rgb : i_pack_a.rgb;
    end

endmodule : stream_select

// File: src/video_out.sv
`timescale 1ns/10ps

module video_out (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  video_pkg::pixel_pack_t i_pack,
    output logic                   o_vsync,
    output logic                   o_hsync,
    output logic                   o_de,
    output logic [7:0]             o_r,
    output logic [7:0]             o_g,
    output logic [7:0]             o_b
);

    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;

    assign r5 = i_pack.rgb[15:11];
    assign g6 = i_pack.rgb[10:5];
    assign b5 = i_pack.rgb[4:0];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_vsync <= 1'b0;
            o_hsync <= 1'b0;
            o_de    <= 1'b0;
            o_r     <= '0;
            o_g     <= '0;
            o_b     <= '0;
        end else begin
            o_vsync <= i_pack.vsync;
            o_hsync <= i_pack.href;                 // Line active drives the hsync pin
            o_de    <= i_pack.de;
            if (i_pack.de) begin
                o_r <= {r5, r5[4:2]};               // Top bits refill the low bits
                o_g <= {g6, g6[5:4]};
                o_b <= {b5, b5[4:2]};
            end else begin
                o_r <= '0;
                o_g <= '0;
                o_b <= '0;
            end
        end
    end

endmodule : video_out

// File: testbench/aim_video_props.sv
`timescale 1ns/10ps

module aim_video_props (
    input logic clk,
    input logic i_rst_n,
    input logic i_penable,
    input logic o_pready,
    input logic o_pslverr,
    input logic o_de,
    input logic o_vsync
);

    int fail_count = 0;                              // Failed properties so far

    a_pready_access: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_pready |-> i_penable)
        else begin
            $error("PREADY high outside an access phase");
            fail_count++;
        end

    a_slverr_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_pslverr |-> o_pready)
        else begin
            $error("PSLVERR high without PREADY");
            fail_count++;
        end

    a_de_reset: assert property (@(posedge clk) !i_rst_n |=> !o_de)
        else begin
            $error("Data enable high during reset");
            fail_count++;
        end

    a_de_blank: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_de && o_vsync))
        else begin
            $error("Data enable high while vsync is high");
            fail_count++;
        end

endmodule : aim_video_props

bind aim_video_top aim_video_props u_props (
    .clk      (clk      ),
    .i_rst_n  (i_rst_n  ),
    .i_penable(i_penable),
    .o_pready (o_pready ),
    .o_pslverr(o_pslverr),
    .o_de     (o_de     ),
    .o_vsync  (o_vsync  )
);

// File: testbench/aim_video_testdata.hex
// Low nibble is the kind: 1 APB write, 2 APB read, 3 vsync, 4 camera line, F end
// Write: data addr kind. Read: err data addr kind. Vsync: cycles kind
// Line: RGB888 x0..x7, cam2 high byte, cam1 high byte, byte count, kind
000000000002 000000000042 000000000082 0000000000C2
FFFFFFFF001 F805F802041 FC02FC01081 ABCDF8000C1
000000003002 000050002042 000020001082 00000F8000C2 100000000202
00000000001
033
0800000800080800100800180800210800290800310800398108104
1000001000081000101000181000211000291000311000398210104
1800001800081800101800181800211800291800311800398318104
2100002100082100102100182100212100292100312100398420104
033 00000002001
0800000800080800100800180800210800290800310800398108104
100000100008FF0000FF0000FF0000FF00001000311000398210104
180000180008FF0000FF0000FF0000FF00001800311800398318104
2100002100082100102100182100212100292100312100398420104
033
0800000800080800100800180800210800290800310800398108104
100000100008FF0000FF0000FF0000FF00001000311000398210104
00000003001
180000180008FF0000FF0000FF0000FF00001800311800398318104
2100002100082100102100182100212100292100312100398420104
033
8420008420088420108420188420218420298420318420398108154
844100844108FF0000FF0000FF0000FF00008441318441398210104
846100846108FF0000FF0000FF0000FF00008461318461398318104
8482008482088482108482188482218482298482318482398420104
F

// File: testbench/tb_aim_video.sv
`timescale 1ns/10ps

module tb_aim_video;

    localparam int H_ACT     = 8;
    localparam int V_ACT     = 4;
    localparam int BORDER    = 1;
    localparam int REC_DEPTH = 64;
    localparam int REC_W     = 220;                  // Widest record is a camera line

    localparam logic [3:0] T_WRITE = 4'h1;
    localparam logic [3:0] T_READ  = 4'h2;
    localparam logic [3:0] T_VSYNC = 4'h3;
    localparam logic [3:0] T_LINE  = 4'h4;
    localparam logic [3:0] T_END   = 4'hF;

    typedef struct packed {
        logic       vsync;
        logic       href;
        logic       byte_en;
        logic [7:0] data;
    } cam_in_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_in_t;

    logic        clk;
    logic        i_rst_n;
    cam_in_t     cam1;
    cam_in_t     cam2;
    apb_in_t     apb;
    logic [31:0] o_prdata;
    logic        o_pready;
    logic        o_pslverr;
    logic        o_vsync;
    logic        o_hsync;
    logic        o_de;
    logic [7:0]  o_r;
    logic [7:0]  o_g;
    logic [7:0]  o_b;

    logic [REC_W-1:0] recs [REC_DEPTH];
    logic [23:0]      got_q[$];                      // RGB888 pixels seen on the output
    logic [23:0]      exp_q[$];
    int               apb_errors = 0;
    int               pixel_errors = 0;
    int               other_errors = 0;
    int               cycles = 0;
    int               cycle_limit = 200;
    int               lines_seen = 0;                // Rising edges of hsync and vsync
    int               frames_seen = 0;
    int               lines_expected = 0;
    int               frames_expected = 0;
    logic             hsync_q = 1'b0;
    logic             vsync_q = 1'b0;

    aim_video_top #(.H_ACT(H_ACT), .V_ACT(V_ACT), .BORDER(BORDER)) aim_video_top_inst (
        .clk           (clk         ),
        .i_rst_n       (i_rst_n     ),
        .i_cam1_vsync  (cam1.vsync  ),
        .i_cam1_href   (cam1.href   ),
        .i_cam1_byte_en(cam1.byte_en),
        .i_cam1_data   (cam1.data   ),
        .i_cam2_vsync  (cam2.vsync  ),
        .i_cam2_href   (cam2.href   ),
        .i_cam2_byte_en(cam2.byte_en),
        .i_cam2_data   (cam2.data   ),
        .i_psel        (apb.psel    ),
        .i_penable     (apb.penable ),
        .i_pwrite      (apb.pwrite  ),
        .i_paddr       (apb.paddr   ),
        .i_pwdata      (apb.pwdata  ),
        .o_prdata      (o_prdata    ),
        .o_pready      (o_pready    ),
        .o_pslverr     (o_pslverr   ),
        .o_vsync       (o_vsync     ),
        .o_hsync       (o_hsync     ),
        .o_de          (o_de        ),
        .o_r           (o_r         ),
        .o_g           (o_g         ),
        .o_b           (o_b         )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (i_rst_n) begin
            if (o_de) begin
                got_q.push_back({o_r, o_g, o_b});
                if (!o_hsync) begin
                    $display("FAIL %0t ns: data enable high while hsync is low", $time);
                    other_errors++;
                end
            end
            if (o_hsync && !hsync_q) begin
                lines_seen++;
            end
            if (o_vsync && !vsync_q) begin
                frames_seen++;
            end
        end
        hsync_q = o_hsync;
        vsync_q = o_vsync;
    end

    //////////////////////////////
    // Record helpers
    //////////////////////////////

    function automatic int record_cycles(input logic [REC_W-1:0] rec);
        case (rec[3:0])
            T_WRITE, T_READ: return 4;
            T_VSYNC:         return int'(rec[11:4]) + 24;   // Includes the frame drain
            T_LINE:          return int'(rec[11:4]) + 3;
            default:         return 0;
        endcase
    endfunction

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        waited = 0;
        @(negedge clk);
        apb = {1'b1, 1'b0, write, addr, wdata};
        @(negedge clk);
        apb.penable = 1'b1;
        while (!o_pready && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        rdata = o_prdata;
        err   = o_pslverr;
        if (!o_pready) begin
            $display("APB access to 0x%h at %0t ns never saw PREADY", addr, $time);
            apb_errors++;
        end
        @(negedge clk);
        apb = '0;
    endtask

    task automatic drive_vsync(input int hold);
        @(negedge clk);
        cam1.vsync = 1'b1;
        cam2.vsync = 1'b1;
        repeat (hold) @(negedge clk);
        cam1.vsync = 1'b0;
        cam2.vsync = 1'b0;
        @(negedge clk);
    endtask

    // Even bytes carry the line's high byte, odd bytes the pair index
    task automatic drive_line(input logic [REC_W-1:0] rec);
        int         nbytes;
        int         i;
        logic [7:0] lo;
        nbytes = int'(rec[11:4]);
        for (i = 0; i < nbytes; i++) begin
            @(negedge clk);
            lo   = 8'(i / 2);
            cam1 = {1'b0, 1'b1, 1'b1, (i % 2 == 0) ? rec[19:12] : lo};
            cam2 = {1'b0, 1'b1, 1'b1, (i % 2 == 0) ? rec[27:20] : lo};
        end
        @(negedge clk);
        cam1 = '0;
        cam2 = '0;
        @(negedge clk);
        for (i = 0; i < H_ACT; i++) begin
            exp_q.push_back(rec[28 + 24 * (H_ACT - 1 - i) +: 24]);
        end
    endtask

    task automatic check_frame();
        int          waited;
        int          n;
        logic [23:0] got;
        logic [23:0] want;
        waited = 0;
        n      = 0;
        while (got_q.size() < exp_q.size() && waited < 16) begin
            @(posedge clk);
            waited++;
        end
        if (got_q.size() != exp_q.size()) begin
            $display("FAIL %0t ns: frame gave %0d pixels, expected %0d",
                     $time, got_q.size(), exp_q.size());
            pixel_errors++;
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            got  = got_q.pop_front();
            want = exp_q.pop_front();
            if (got !== want) begin
                $display("FAIL %0t ns: pixel %0d of frame is %h, expected %h",
                         $time, n, got, want);
                pixel_errors++;
            end
            n++;
        end
        got_q.delete();
        exp_q.delete();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        logic [REC_W-1:0] rec;
        logic [31:0]      rdata;
        logic             err;
        int               idx;
        int               total;
        bit               done;
        cam1    = '0;
        cam2    = '0;
        apb     = '0;
        i_rst_n = 1'b0;
        $readmemh("testbench/aim_video_testdata.hex", recs);
        idx = 0;
        while (idx < REC_DEPTH && recs[idx][3:0] != T_END) begin
            cycle_limit += record_cycles(recs[idx]);
            if (recs[idx][3:0] == T_LINE) begin
                lines_expected++;
            end else if (recs[idx][3:0] == T_VSYNC) begin
                frames_expected++;
            end
            idx++;
        end
        repeat (4) @(negedge clk);
        i_rst_n = 1'b1;

        idx  = 0;
        done = 1'b0;
        while (!done) begin
            rec = recs[idx];
            case (rec[3:0])
                T_WRITE: apb_access(1'b1, rec[11:4], rec[43:12], rdata, err);
                T_READ: begin
                    apb_access(1'b0, rec[11:4], 32'd0, rdata, err);
                    if (rdata !== rec[43:12] || err !== rec[44]) begin
                        $display("FAIL %0t ns: read of 0x%h gave 0x%h err %0b, expected 0x%h err %0b",
                                 $time, rec[11:4], rdata, err, rec[43:12], rec[44]);
                        apb_errors++;
                    end
                end
                T_VSYNC: begin
                    check_frame();                           // Previous frame is complete
                    drive_vsync(int'(rec[11:4]));
                end
                T_LINE:  drive_line(rec);
                T_END:   done = 1'b1;
                default: begin
                    $display("Record %0d has an unknown kind, stopping the sequence", idx);
                    other_errors++;
                    done = 1'b1;
                end
            endcase
            idx++;
            if (idx >= REC_DEPTH) begin
                done = 1'b1;
            end
        end
        check_frame();

        if (lines_seen != lines_expected || frames_seen != frames_expected) begin
            $display("FAIL %0t ns: saw %0d lines and %0d frames, expected %0d and %0d",
                     $time, lines_seen, frames_seen, lines_expected, frames_expected);
            other_errors++;
        end

        total = apb_errors + pixel_errors + other_errors + aim_video_top_inst.u_props.fail_count;
        $display("Errors: apb %0d, pixel %0d, other %0d, assertion %0d",
                 apb_errors, pixel_errors, other_errors, aim_video_top_inst.u_props.fail_count);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule : tb_aim_video
